// ==== Makefile ====
# Verilator simulation of the native to AXI4-Lite bridge subsystem.
# Every variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_axil_bridge_top
FILELIST  ?= axil_bridge_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

# Build, run, and decide pass or fail from the log.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== axil_bridge_top.f ====
+incdir+source
source/bridge_pkg.sv
source/native_decoder.sv
source/native_to_axil.sv
source/axil_window_regs.sv
source/axil_bridge_top.sv
tb/tb_axil_bridge_top.sv

// ==== source/axil_bridge_top.sv ====
`timescale 1ns/1ps

`include "bridge_defines.svh"

module axil_bridge_top
   import bridge_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,

   input  logic        valid_i,
   input  native_req_t req_i,
   output native_rsp_t rsp_o
);

   logic [`BRIDGE_NUM_PORTS-1:0] port_valid;
   native_req_t                  port_req;
   native_rsp_t                  port_rsp [`BRIDGE_NUM_PORTS];
   axil_m2s_t                    axil_m2s [`BRIDGE_NUM_PORTS];
   axil_s2m_t                    axil_s2m [`BRIDGE_NUM_PORTS];

   native_decoder native_decoder_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .valid_i      (valid_i),
      .req_i        (req_i),
      .rsp_o        (rsp_o),
      .port_valid_o (port_valid),
      .port_req_o   (port_req),
      .port_rsp_i   (port_rsp)
   );

   // one bridge per register window.
   for (genvar k = 0; k < `BRIDGE_NUM_PORTS; k++) begin : g_bridge
      native_to_axil native_to_axil_i (
         .clk_i   (clk_i),
         .rst_i   (rst_i),
         .valid_i (port_valid[k]),
         .req_i   (port_req),
         .rsp_o   (port_rsp[k]),
         .axil_o  (axil_m2s[k]),
         .axil_i  (axil_s2m[k])
      );
   end

   axil_window_regs axil_window_regs_i (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .axil_i (axil_m2s),
      .axil_o (axil_s2m)
   );

endmodule

// ==== source/axil_window_regs.sv ====
`timescale 1ns/1ps

`include "bridge_defines.svh"

module axil_window_regs
   import bridge_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,

   input  axil_m2s_t axil_i [`BRIDGE_NUM_PORTS],
   output axil_s2m_t axil_o [`BRIDGE_NUM_PORTS]
);

   for (genvar p = 0; p < `BRIDGE_NUM_PORTS; p++) begin : g_port
      logic [`BRIDGE_DATA_W-1:0] mem_q [`BRIDGE_NUM_WORDS];
      logic [`BRIDGE_WORD_W-1:0] wr_idx;
      logic [`BRIDGE_WORD_W-1:0] rd_idx;
      logic                      wr_pend_q;
      logic                      wready_q;
      logic                      bvalid_q;
      logic                      rd_pend_q;
      logic                      arready_q;
      logic                      rvalid_q;
      logic [`BRIDGE_DATA_W-1:0] rdata_q;
      logic                      wr_go;
      logic                      wr_hs;
      logic                      rd_go;
      logic                      ar_hs;

      assign wr_idx = axil_i[p].awaddr[`BRIDGE_WIN_W-1:2];   // upper bits are ignored.
      assign rd_idx = axil_i[p].araddr[`BRIDGE_WIN_W-1:2];

      assign wr_go = axil_i[p].awvalid & axil_i[p].wvalid & ~wr_pend_q;
      assign wr_hs = wready_q & axil_i[p].awvalid & axil_i[p].wvalid;
      assign rd_go = axil_i[p].arvalid & ~rd_pend_q;
      assign ar_hs = arready_q & axil_i[p].arvalid;

      always_ff @(posedge clk_i or posedge rst_i) begin
         if (rst_i) begin
            wr_pend_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            rd_pend_q <= 1'b0;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            for (int w = 0; w < `BRIDGE_NUM_WORDS; w++) begin
               mem_q[w] <= '0;
            end
         end else begin
            wready_q <= wr_go;   // one cycle pulse serving both AW and W.
            if (wr_go) begin
               wr_pend_q <= 1'b1;
            end else if (bvalid_q & axil_i[p].bready) begin
               wr_pend_q <= 1'b0;
            end
            if (wr_hs) begin
               bvalid_q <= 1'b1;
            end else if (axil_i[p].bready) begin
               bvalid_q <= 1'b0;
            end
            if (wr_hs) begin
               for (int b = 0; b < `BRIDGE_STRB_W; b++) begin
                  if (axil_i[p].wstrb[b]) begin
                     mem_q[wr_idx][8*b +: 8] <= axil_i[p].wdata[8*b +: 8];
                  end
               end
            end

            arready_q <= rd_go;
            if (rd_go) begin
               rd_pend_q <= 1'b1;
            end else if (rvalid_q & axil_i[p].rready) begin
               rd_pend_q <= 1'b0;
            end
            if (ar_hs) begin
               rvalid_q <= 1'b1;   // data is held until the bridge takes it.
            end else if (axil_i[p].rready) begin
               rvalid_q <= 1'b0;
            end
         end
      end

      always_ff @(posedge clk_i) begin
         if (ar_hs) begin
            rdata_q <= mem_q[rd_idx];
         end
      end

      assign axil_o[p].awready = wready_q;
      assign axil_o[p].wready  = wready_q;
      assign axil_o[p].bvalid  = bvalid_q;
      assign axil_o[p].arready = arready_q;
      assign axil_o[p].rvalid  = rvalid_q;
      assign axil_o[p].rdata   = rdata_q;
   end

endmodule

// ==== source/bridge_defines.svh ====
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// Native side and AXI4-Lite side share one address width.
`define BRIDGE_ADDR_W 32

// Data bus width in bits.
`define BRIDGE_DATA_W 32

// One strobe bit per data byte.
`define BRIDGE_STRB_W (`BRIDGE_DATA_W / 8)

// Number of register windows, one bridge per window.
`define BRIDGE_NUM_PORTS 4

// Address bits that pick the window.
`define BRIDGE_SEL_W 2

// Byte offset bits inside one window.
`define BRIDGE_WIN_W 6

// Word offset bits inside one window (byte offset minus the byte lane bits).
`define BRIDGE_WORD_W (`BRIDGE_WIN_W - 2)

// Number of 32-bit registers in each window.
`define BRIDGE_NUM_WORDS (1 << `BRIDGE_WORD_W)

`endif

// ==== source/bridge_pkg.sv ====
package bridge_pkg;

`include "bridge_defines.svh"

   // one native request, held steady while valid is high.
   typedef struct packed {
      logic [`BRIDGE_ADDR_W-1:0] addr;
      logic [`BRIDGE_DATA_W-1:0] wdata;
      logic [`BRIDGE_STRB_W-1:0] wstrb;   // all zero means a read.
   } native_req_t;

   typedef struct packed {
      logic [`BRIDGE_DATA_W-1:0] rdata;   // valid in the ready cycle.
      logic                      ready;   // one cycle per request.
   } native_rsp_t;

   // AXI4-Lite signals driven by a bridge towards the slave.
   typedef struct packed {
      logic                      awvalid;
      logic [`BRIDGE_ADDR_W-1:0] awaddr;
      logic                      wvalid;
      logic [`BRIDGE_DATA_W-1:0] wdata;
      logic [`BRIDGE_STRB_W-1:0] wstrb;
      logic                      bready;
      logic                      arvalid;
      logic [`BRIDGE_ADDR_W-1:0] araddr;
      logic                      rready;
   } axil_m2s_t;

   // AXI4-Lite signals driven by the slave back to a bridge.
   typedef struct packed {
      logic                      awready;
      logic                      wready;
      logic                      bvalid;
      logic                      arready;
      logic                      rvalid;
      logic [`BRIDGE_DATA_W-1:0] rdata;
   } axil_s2m_t;

endpackage

// ==== source/native_decoder.sv ====
`timescale 1ns/1ps

`include "bridge_defines.svh"

module native_decoder
   import bridge_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          rst_i,

   input  logic                          valid_i,
   input  native_req_t                   req_i,
   output native_rsp_t                   rsp_o,

   output logic [`BRIDGE_NUM_PORTS-1:0]  port_valid_o,
   output native_req_t                   port_req_o,
   input  native_rsp_t                   port_rsp_i [`BRIDGE_NUM_PORTS]
);

   logic [`BRIDGE_SEL_W-1:0] req_sel;
   logic [`BRIDGE_SEL_W-1:0] sel_q;
   logic [`BRIDGE_SEL_W-1:0] sel;
   logic                     busy_q;
   logic                     start;

   assign req_sel = req_i.addr[`BRIDGE_WIN_W +: `BRIDGE_SEL_W];   // window above the offset.

   // a request starts on the first valid cycle not yet owned by a transaction.
   assign start = valid_i & ~busy_q;

   assign sel = start ? req_sel : sel_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_q <= 1'b0;
         sel_q  <= '0;
      end else begin
         busy_q <= valid_i & ~rsp_o.ready;   // ends with the ready pulse or a dropped valid.
         if (start) begin
            sel_q <= req_sel;
         end
      end
   end

   always_comb begin
      for (int k = 0; k < `BRIDGE_NUM_PORTS; k++) begin
         port_valid_o[k] = valid_i & (sel == `BRIDGE_SEL_W'(k));
      end
   end

   assign port_req_o = req_i;   // every bridge sees the same request.

   assign rsp_o = port_rsp_i[sel];

endmodule

// ==== source/native_to_axil.sv ====
`timescale 1ns/1ps

`include "bridge_defines.svh"

module native_to_axil
   import bridge_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,

   input  logic        valid_i,
   input  native_req_t req_i,
   output native_rsp_t rsp_o,

   output axil_m2s_t   axil_o,
   input  axil_s2m_t   axil_i
);

   logic                      wr;
   logic                      rd;
   logic                      wr_q;
   logic                      rd_q;

   logic                      aw_ack_q;
   logic                      w_ack_q;
   logic                      ar_ack_q;
   logic                      r_ack_q;

   logic                      awvalid;
   logic                      wvalid;
   logic                      arvalid;
   logic                      rready;

   logic                      r_hs;
   logic                      rd_done_q;
   logic [`BRIDGE_DATA_W-1:0] rdata_q;

   assign wr = valid_i & (|req_i.wstrb);
   assign rd = valid_i & ~(|req_i.wstrb);

   // each channel valid drops for good once its own handshake is done.
   assign awvalid = wr & ~aw_ack_q;
   assign wvalid  = wr & ~w_ack_q;
   assign arvalid = rd & ~ar_ack_q;
   assign rready  = rd & ~r_ack_q;

   assign r_hs = axil_i.rvalid & rready;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_q      <= 1'b0;
         rd_q      <= 1'b0;
         rd_done_q <= 1'b0;
      end else begin
         wr_q      <= wr;
         rd_q      <= rd;
         rd_done_q <= r_hs;   // read ready follows the R handshake by one cycle.
      end
   end

   // The flags are released when the request goes away, not on the response,
   // so a valid still high after ready cannot start a second transaction.
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         aw_ack_q <= 1'b0;
         w_ack_q  <= 1'b0;
      end else if (wr_q & ~wr) begin
         aw_ack_q <= 1'b0;
         w_ack_q  <= 1'b0;
      end else begin
         if (awvalid & axil_i.awready) begin
            aw_ack_q <= 1'b1;
         end
         if (wvalid & axil_i.wready) begin
            w_ack_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ar_ack_q <= 1'b0;
         r_ack_q  <= 1'b0;
      end else if (rd_q & ~rd) begin
         ar_ack_q <= 1'b0;
         r_ack_q  <= 1'b0;
      end else begin
         if (arvalid & axil_i.arready) begin
            ar_ack_q <= 1'b1;
         end
         if (r_hs) begin
            r_ack_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (r_hs) begin
         rdata_q <= axil_i.rdata;
      end
   end

   assign axil_o.awvalid = awvalid;
   assign axil_o.awaddr  = req_i.addr;
   assign axil_o.wvalid  = wvalid;
   assign axil_o.wdata   = req_i.wdata;
   assign axil_o.wstrb   = req_i.wstrb;
   assign axil_o.bready  = 1'b1;   // write responses are always taken.
   assign axil_o.arvalid = arvalid;
   assign axil_o.araddr  = req_i.addr;
   assign axil_o.rready  = rready;

   assign rsp_o.rdata = rdata_q;
   assign rsp_o.ready = axil_i.bvalid | rd_done_q;

endmodule

// ==== tb/tb_axil_bridge_top.sv ====
`timescale 1ns/1ps

`include "bridge_defines.svh"

module tb_axil_bridge_top
   import bridge_pkg::*;
;

   localparam int HIGH_W = `BRIDGE_ADDR_W - `BRIDGE_SEL_W - `BRIDGE_WIN_W;

   logic        clk_i;
   logic        rst_i;
   logic        valid;
   native_req_t req;
   native_rsp_t rsp;

   logic [`BRIDGE_DATA_W-1:0] model_mem [`BRIDGE_NUM_PORTS][`BRIDGE_NUM_WORDS];
   int                        req_count;
   int                        pulse_count;

   axil_bridge_top axil_bridge_top_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (valid),
      .req_i   (req),
      .rsp_o   (rsp)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // sampled on the falling edge, before the stimulus for that edge is applied.
   assert property (@(negedge clk_i) rst_i |-> !rsp.ready)
      else stop_on_error($sformatf("Mismatch at %0t: ready high during reset", $time));
   assert property (@(negedge clk_i) disable iff (rst_i) rsp.ready |-> valid)
      else stop_on_error($sformatf("Mismatch at %0t: ready high while valid is low", $time));
   assert property (@(negedge clk_i) disable iff (rst_i) rsp.ready |=> !rsp.ready)
      else stop_on_error($sformatf("Mismatch at %0t: ready high in two cycles", $time));

   always @(negedge clk_i) begin
      if (!rst_i && rsp.ready) begin
         pulse_count++;
      end
   end

   function automatic logic [`BRIDGE_ADDR_W-1:0] make_addr(input logic [`BRIDGE_SEL_W-1:0] win,
                                                          input logic [`BRIDGE_WORD_W-1:0] word,
                                                          input logic [HIGH_W-1:0] high);
      return {high, win, word, 2'b00};
   endfunction

   // byte lanes with a strobe bit take the new data, the others keep the old word.
   function automatic logic [`BRIDGE_DATA_W-1:0] merge_bytes(
      input logic [`BRIDGE_DATA_W-1:0] old_word,
      input logic [`BRIDGE_DATA_W-1:0] new_word,
      input logic [`BRIDGE_STRB_W-1:0] strb);
      logic [`BRIDGE_DATA_W-1:0] result;
      result = old_word;
      for (int b = 0; b < `BRIDGE_STRB_W; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   task automatic drive_request(input logic [`BRIDGE_ADDR_W-1:0] addr,
                                input logic [`BRIDGE_DATA_W-1:0] wdata,
                                input logic [`BRIDGE_STRB_W-1:0] strb,
                                output logic [`BRIDGE_DATA_W-1:0] rdata);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      rdata  = '0;
      @(negedge clk_i);
      valid     = 1'b1;
      req.addr  = addr;
      req.wdata = wdata;
      req.wstrb = strb;
      while (!seen) begin
         @(negedge clk_i);
         if (rsp.ready) begin
            seen  = 1'b1;
            rdata = rsp.rdata;
         end else begin
            cycles++;
            if (cycles >= 32) begin
               stop_on_error($sformatf("no ready pulse within 32 cycles for address %h", addr));
            end
         end
      end
      valid = 1'b0;   // the request ends with its ready pulse.
      req   = '0;
      req_count++;
   endtask

   task automatic write_word(input logic [`BRIDGE_SEL_W-1:0] win,
                             input logic [`BRIDGE_WORD_W-1:0] word,
                             input logic [HIGH_W-1:0] high,
                             input logic [`BRIDGE_DATA_W-1:0] data,
                             input logic [`BRIDGE_STRB_W-1:0] strb);
      logic [`BRIDGE_DATA_W-1:0] unused_rdata;
      model_mem[win][word] = merge_bytes(model_mem[win][word], data, strb);
      drive_request(make_addr(win, word, high), data, strb, unused_rdata);
   endtask

   task automatic read_and_check(input logic [`BRIDGE_SEL_W-1:0] win,
                                 input logic [`BRIDGE_WORD_W-1:0] word,
                                 input logic [HIGH_W-1:0] high);
      logic [`BRIDGE_DATA_W-1:0] got;
      logic [`BRIDGE_DATA_W-1:0] expected;
      expected = model_mem[win][word];
      drive_request(make_addr(win, word, high), '0, '0, got);
      assert (got == expected)
         else stop_on_error($sformatf("Mismatch at %0t: window %0d word %0d read %h, expected %h",
                                      $time, win, word, got, expected));
   endtask

   initial begin
      logic [`BRIDGE_SEL_W-1:0]  win;
      logic [`BRIDGE_WORD_W-1:0] word;
      logic [HIGH_W-1:0]         high;
      logic [`BRIDGE_STRB_W-1:0] strb;
      void'($urandom(63737));
      rst_i       = 1'b1;
      valid       = 1'b0;
      req         = '0;
      req_count   = 0;
      pulse_count = 0;
      for (int w = 0; w < `BRIDGE_NUM_PORTS; w++) begin
         for (int i = 0; i < `BRIDGE_NUM_WORDS; i++) begin
            model_mem[w][i] = '0;
         end
      end
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      // idle bus after reset, then every register must read zero.
      repeat (4) begin
         @(negedge clk_i);
         assert (!rsp.ready) else stop_on_error("ready pulse seen with no request after reset");
      end
      for (int w = 0; w < `BRIDGE_NUM_PORTS; w++) begin
         for (int i = 0; i < `BRIDGE_NUM_WORDS; i++) begin
            read_and_check(`BRIDGE_SEL_W'(w), `BRIDGE_WORD_W'(i), '0);
         end
      end

      write_word(2'd1, 4'd3, '0, 32'hDEADBEEF, 4'hF);
      read_and_check(2'd1, 4'd3, '0);

      write_word(2'd2, 4'd5, '0, 32'h11223344, 4'hF);
      write_word(2'd2, 4'd5, '0, 32'hAABBCCDD, 4'b0101);
      read_and_check(2'd2, 4'd5, '0);
      write_word(2'd2, 4'd5, '0, 32'h99887766, 4'b1000);
      read_and_check(2'd2, 4'd5, '0);

      // same offset in each window with a different value.
      for (int w = 0; w < `BRIDGE_NUM_PORTS; w++) begin
         write_word(`BRIDGE_SEL_W'(w), 4'd9, '0, 32'hC0DE0000 + 32'(w * 32'h1111), 4'hF);
      end
      for (int w = 0; w < `BRIDGE_NUM_PORTS; w++) begin
         read_and_check(`BRIDGE_SEL_W'(w), 4'd9, '0);
      end

      for (int n = 0; n < 200; n++) begin
         win  = `BRIDGE_SEL_W'($urandom_range(0, `BRIDGE_NUM_PORTS - 1));
         word = `BRIDGE_WORD_W'($urandom_range(0, `BRIDGE_NUM_WORDS - 1));
         high = HIGH_W'($urandom);   // bits above the window select are ignored.
         if ($urandom_range(0, 1) == 1) begin
            strb = `BRIDGE_STRB_W'($urandom_range(1, 15));
            write_word(win, word, high, $urandom, strb);
         end else begin
            read_and_check(win, word, high);
         end
      end

      repeat (2) @(negedge clk_i);
      if (pulse_count == req_count) begin
         $display(">>> PASS");
         $finish;
      end else begin
         stop_on_error($sformatf("Mismatch at %0t: %0d ready pulses for %0d requests",
                                 $time, pulse_count, req_count));
      end
   end

endmodule
